// ==== Makefile ====
VERILATOR ?= verilator
FLAGS = --timing --assert --timescale 1ns/100ps
TOP = soc_tb
FILELIST = soc_top.f
OBJ_DIR = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/soc_tb_tasks.svh ====
`ifndef soc_tb_tasks_svh
`define soc_tb_tasks_svh

    logic [data_w-1:0] ram_model [ram_words];

    function automatic logic [addr_w-1:0] word_address(input int idx);
        return ram_base + addr_w'(4 * idx);
    endfunction

    // the start value of a RAM word is built from its whole index.
    function automatic logic [data_w-1:0] fill_word(input int idx);
        return 32'h5a3c_0000 ^ data_w'(idx * 32'h0001_0203);
    endfunction

    task automatic data_write_word(input logic [addr_w-1:0] addr,
                                   input logic [mask_w-1:0] mask,
                                   input logic [data_w-1:0] value);
        @(negedge pll_clk);
        data_address = addr;
        data_write_mask = mask;
        data_write_value = value;
        data_write = 1'b1;
        do @(negedge pll_clk); while (!data_ready);
        data_write = 1'b0;
    endtask

    task automatic data_read_word(input logic [addr_w-1:0] addr,
                                  output logic [data_w-1:0] value);
        @(negedge pll_clk);
        data_address = addr;
        data_read = 1'b1;
        do @(negedge pll_clk); while (!data_ready);
        value = data_read_value;
        data_read = 1'b0;
    endtask

    task automatic instr_read_word(input logic [addr_w-1:0] addr,
                                   output logic [data_w-1:0] value);
        @(negedge pll_clk);
        instr_address = addr;
        instr_read = 1'b1;
        do @(negedge pll_clk); while (!instr_ready);
        value = instr_read_value;
        instr_read = 1'b0;
    endtask

    // only the byte lanes enabled in the mask change in the model word.
    task automatic ram_write(input int idx, input logic [mask_w-1:0] mask,
                             input logic [data_w-1:0] value);
        data_write_word(word_address(idx), mask, value);
        for (int lane = 0; lane < mask_w; lane++) begin
            if (mask[lane]) begin
                ram_model[idx][lane*8 +: 8] = value[lane*8 +: 8];
            end
        end
    endtask

    // each bit is taken in its middle, counted from the falling edge of the start bit.
    task automatic sample_uart_frame(output logic [7:0] data);
        @(negedge uart_tx);
        repeat (clks_per_bit / 2) @(negedge pll_clk);
        check_equal("uart_tx start bit", 32'd0, 32'(uart_tx));
        for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge pll_clk);
            data[i] = uart_tx;
        end
        repeat (clks_per_bit) @(negedge pll_clk);
        check_equal("uart_tx stop bit", 32'd1, 32'(uart_tx));
    endtask

`endif

// ==== bench/soc_tb.sv ====
`timescale 1ns/100ps

module soc_tb;
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    // about 200 bus accesses of up to 4 cycles and four UART frame times, with margin.
    localparam int frame_cycles = 10 * clks_per_bit;
    localparam int timeout_cycles = (200 * 4 + 4 * frame_cycles + 80) * 5 / 2;

    logic pll_clk = 1'b0;
    logic rst_n = 1'b0;
    logic [addr_w-1:0] instr_address = '0;
    logic instr_read = 1'b0;
    logic [data_w-1:0] instr_read_value;
    logic instr_ready;
    logic [addr_w-1:0] data_address = '0;
    logic data_read = 1'b0;
    logic data_write = 1'b0;
    logic [mask_w-1:0] data_write_mask = '0;
    logic [data_w-1:0] data_write_value = '0;
    logic [data_w-1:0] data_read_value;
    logic data_ready;
    logic [led_w-1:0] leds;
    logic uart_tx;

    integer seed = 30901;
    int error_count = 0;
    int errors_before = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycle_count = 0;

    soc_top DUT (.*);

    always #10 pll_clk = ~pll_clk;

    `include "soc_tb_tasks.svh"

    task automatic fail_check(input string what);
        $display("error at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    // a request seen while the fabric is idle gets ready in the next cycle.
    assert property (@(posedge pll_clk) disable iff (!rst_n)
        (data_read || data_write) && !data_ready && !instr_ready |=> data_ready)
        else fail_check("data_ready did not come one cycle after a data request");
    assert property (@(posedge pll_clk) disable iff (!rst_n)
        instr_read && !data_read && !data_write && !data_ready && !instr_ready |=> instr_ready)
        else fail_check("instr_ready did not come one cycle after an instruction request");
    assert property (@(posedge pll_clk) disable iff (!rst_n)
        (data_ready || instr_ready) |=> !(data_ready || instr_ready))
        else fail_check("a ready output stayed high for two cycles");
    assert property (@(posedge pll_clk) disable iff (!rst_n) !(data_ready && instr_ready))
        else fail_check("instr_ready and data_ready were high together");

    initial begin : watchdog
        while (cycle_count < timeout_cycles) begin
            @(posedge pll_clk);
            cycle_count++;
        end
        $display("timeout: no result after %0d cycles", timeout_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : run
        logic [data_w-1:0] rnd;
        logic [data_w-1:0] value;
        logic [data_w-1:0] later;
        logic [7:0] received;
        int cycles;

        // four cycles in reset, then one more after release.
        for (int cycle = 0; cycle < 5; cycle++) begin
            @(posedge pll_clk);
            @(negedge pll_clk);
            check_equal("{instr_ready, data_ready, leds, uart_tx}", 32'h1,
                        32'({instr_ready, data_ready, leds, uart_tx}));
            rst_n = (cycle >= 3);
        end
        report_test("reset");

        for (int i = 0; i < 16; i++) begin
            ram_write(i, 4'hf, fill_word(i));
        end
        for (int n = 0; n < 64; n++) begin
            rnd = $random(seed);
            value = $random(seed);
            ram_write(int'(rnd[3:0]), rnd[7:4], value);
        end
        for (int i = 0; i < 16; i++) begin
            data_read_word(word_address(i), value);
            check_equal("data_read_value", ram_model[i], value);
            instr_read_word(word_address(i), value);
            check_equal("instr_read_value", ram_model[i], value);
        end
        report_test("ram");

        @(negedge pll_clk);
        data_address = word_address(3);
        data_read = 1'b1;
        instr_address = word_address(9);
        instr_read = 1'b1;
        @(negedge pll_clk);
        check_equal("data_ready", 32'd1, 32'(data_ready));
        check_equal("instr_ready", 32'd0, 32'(instr_ready));
        check_equal("data_read_value", ram_model[3], data_read_value);
        data_read = 1'b0;
        cycles = cycle_count;
        do @(negedge pll_clk); while (!instr_ready);
        // the instruction grant takes the idle cycle after the data ready.
        check_equal("instr_ready delay", 32'd2, cycle_count - cycles);
        check_equal("instr_read_value", ram_model[9], instr_read_value);
        instr_read = 1'b0;
        report_test("arbitration");

        rnd = $random(seed);
        rnd[0] = 1'b1;
        data_write_word(led_base, 4'h1, rnd);
        check_equal("leds", 32'(rnd[led_w-1:0]), 32'(leds));
        data_read_word(led_base, value);
        check_equal("data_read_value", 32'(rnd[led_w-1:0]), value);
        data_write_word(led_base, 4'he, ~rnd);
        check_equal("leds", 32'(rnd[led_w-1:0]), 32'(leds));
        data_read_word(32'h0004_0000, value);
        check_equal("data_read_value", 32'd0, value);
        report_test("leds");

        rnd = $random(seed);
        fork
            sample_uart_frame(received);
            begin
                data_write_word(uart_base + 32'(uart_data_off), 4'hf, rnd);
                data_read_word(uart_base + 32'(uart_status_off), value);
                check_equal("uart busy", 32'd1, value);
                // made while busy, so no frame may follow.
                data_write_word(uart_base + 32'(uart_data_off), 4'hf, ~rnd);
            end
        join
        check_equal("uart frame data", 32'(rnd[7:0]), 32'(received));
        repeat (clks_per_bit) @(negedge pll_clk);
        data_read_word(uart_base + 32'(uart_status_off), value);
        check_equal("uart busy", 32'd0, value);
        cycles = 0;
        repeat (2 * frame_cycles) begin
            @(negedge pll_clk);
            cycles = cycles + (uart_tx ? 0 : 1);
        end
        check_equal("uart_tx low cycles", 32'd0, cycles);
        report_test("uart");

        data_read_word(timer_base + 32'(timer_lo_off), value);
        cycles = cycle_count;
        repeat (10) @(negedge pll_clk);
        data_read_word(timer_base + 32'(timer_lo_off), later);
        // both reads are uncontested, so ready cycles lie as far apart as the grants.
        check_equal("timer delta", 32'(cycle_count - cycles), later - value);
        data_read_word(timer_base + 32'(timer_hi_off), value);
        check_equal("timer high", 32'd0, value);
        report_test("timer");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== soc_top.f ====
+incdir+bench
verilog/soc_bus_pkg.sv
verilog/soc_periph_pkg.sv
verilog/bus_fabric.sv
verilog/ram.sv
verilog/uart_tx.sv
verilog/periph_regs.sv
verilog/soc_top.sv
bench/soc_tb.sv

// ==== verilog/bus_fabric.sv ====
`timescale 1ns/100ps

module bus_fabric (
    input logic pll_clk,
    input logic rst_n,

    input logic [soc_bus_pkg::addr_w-1:0] instr_address,
    input logic instr_read,
    output logic [soc_bus_pkg::data_w-1:0] instr_read_value,
    output logic instr_ready,

    input logic [soc_bus_pkg::addr_w-1:0] data_address,
    input logic data_read,
    input logic data_write,
    input logic [soc_bus_pkg::mask_w-1:0] data_write_mask,
    input logic [soc_bus_pkg::data_w-1:0] data_write_value,
    output logic [soc_bus_pkg::data_w-1:0] data_read_value,
    output logic data_ready,

    output logic [soc_bus_pkg::addr_w-1:0] mem_address,
    output logic mem_read,
    output logic mem_write,
    output logic [soc_bus_pkg::mask_w-1:0] mem_write_mask,
    output logic [soc_bus_pkg::data_w-1:0] mem_write_value,
    output logic ram_sel,
    output logic uart_sel,
    output logic periph_sel,

    input logic [soc_bus_pkg::data_w-1:0] ram_read_value,
    input logic [soc_bus_pkg::data_w-1:0] uart_read_value,
    input logic [soc_bus_pkg::data_w-1:0] periph_read_value
);
    import soc_bus_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_ack_instr,
        st_ack_data
    } state_t;

    state_t state;
    state_t state_next;

    logic grant_instr;
    logic grant_data;
    logic granted;
    logic [data_w-1:0] merged_read_value;

    function automatic logic in_region(
        input logic [addr_w-1:0] addr,
        input logic [addr_w-1:0] base,
        input logic [addr_w-1:0] size
    );
        return (addr - base) < size;
    endfunction

    // the data master wins when both request in the same idle cycle.
    assign grant_data = (state == st_idle) && (data_read || data_write);
    assign grant_instr = (state == st_idle) && !grant_data && instr_read;
    assign granted = grant_data || grant_instr;

    assign mem_address = grant_instr ? instr_address : data_address;
    assign mem_read = grant_data ? data_read : grant_instr;
    assign mem_write = grant_data && data_write;
    assign mem_write_mask = data_write_mask;
    assign mem_write_value = data_write_value;

    // an address outside every region leaves all selects low.
    assign ram_sel = granted && in_region(mem_address, ram_base, ram_bytes);
    assign uart_sel = granted && in_region(mem_address, uart_base, region_bytes);
    assign periph_sel = granted && (in_region(mem_address, led_base, region_bytes) ||
                                    in_region(mem_address, timer_base, region_bytes));

    always_comb begin
        state_next = st_idle;
        if (grant_data) begin
            state_next = st_ack_data;
        end else if (grant_instr) begin
            state_next = st_ack_instr;
        end
    end

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // slaves return zero when not selected, so an OR merges them.
    assign merged_read_value = ram_read_value | uart_read_value | periph_read_value;

    assign instr_ready = (state == st_ack_instr);
    assign data_ready = (state == st_ack_data);

    assign instr_read_value = instr_ready ? merged_read_value : '0;
    assign data_read_value = data_ready ? merged_read_value : '0;

endmodule

// ==== verilog/periph_regs.sv ====
`timescale 1ns/100ps

module periph_regs (
    input logic pll_clk,
    input logic rst_n,

    input logic [soc_bus_pkg::addr_w-1:0] mem_address,
    input logic periph_sel,
    input logic mem_write,
    input logic [soc_bus_pkg::mask_w-1:0] mem_write_mask,
    input logic [soc_bus_pkg::data_w-1:0] mem_write_value,
    output logic [soc_bus_pkg::data_w-1:0] periph_read_value,

    output logic [soc_periph_pkg::led_w-1:0] leds
);
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    logic is_timer;
    logic [3:0] reg_off;
    logic [2*data_w-1:0] cycle_cnt;
    logic [data_w-1:0] read_next;

    // periph_sel covers the LED and timer regions, told apart by the region number.
    assign is_timer = (mem_address[addr_w-1:region_bits] == timer_base[addr_w-1:region_bits]);
    assign reg_off = mem_address[region_bits-1:0];

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            leds <= '0;
        end else if (periph_sel && mem_write && !is_timer && mem_write_mask[0]) begin
            leds <= mem_write_value[led_w-1:0];
        end
    end

    always_comb begin
        read_next = '0;
        if (is_timer) begin
            if (reg_off == timer_lo_off) begin
                read_next = cycle_cnt[data_w-1:0];
            end else if (reg_off == timer_hi_off) begin
                read_next = cycle_cnt[2*data_w-1:data_w];
            end
        end else begin
            read_next = {{(data_w-led_w){1'b0}}, leds};
        end
    end

    // the count is captured in the grant cycle itself.
    always_ff @(posedge pll_clk) begin
        periph_read_value <= periph_sel ? read_next : '0;
    end

endmodule

// ==== verilog/ram.sv ====
`timescale 1ns/100ps

module ram (
    input logic pll_clk,

    input logic [soc_bus_pkg::addr_w-1:0] mem_address,
    input logic ram_sel,
    input logic mem_write,
    input logic [soc_bus_pkg::mask_w-1:0] mem_write_mask,
    input logic [soc_bus_pkg::data_w-1:0] mem_write_value,
    output logic [soc_bus_pkg::data_w-1:0] ram_read_value
);
    import soc_bus_pkg::*;

    logic [data_w-1:0] mem [ram_words];
    logic [ram_idx_w-1:0] word_idx;

    assign word_idx = mem_address[ram_idx_w+1:2];

    // each enabled byte lane is written on its own.
    always_ff @(posedge pll_clk) begin
        if (ram_sel && mem_write) begin
            for (int lane = 0; lane < mask_w; lane++) begin
                if (mem_write_mask[lane]) begin
                    mem[word_idx][lane*8 +: 8] <= mem_write_value[lane*8 +: 8];
                end
            end
        end
    end

    // a read in the same cycle as a write returns the old word.
    always_ff @(posedge pll_clk) begin
        if (ram_sel) begin
            ram_read_value <= mem[word_idx];
        end else begin
            ram_read_value <= '0;
        end
    end

endmodule

// ==== verilog/soc_bus_pkg.sv ====
package soc_bus_pkg;

    // widths of the common memory bus.
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int mask_w = data_w / 8;

    // the RAM is organized as 32-bit words, indexed by address bits above the byte lanes.
    localparam int ram_words = 256;
    localparam int ram_idx_w = $clog2(ram_words);

    localparam logic [addr_w-1:0] ram_base = 32'h0000_0000;
    localparam logic [addr_w-1:0] ram_bytes = addr_w'(mask_w * ram_words);

    // each peripheral region spans 16 bytes of address space.
    localparam int region_bits = 4;
    localparam logic [addr_w-1:0] region_bytes = addr_w'(1 << region_bits);

    localparam logic [addr_w-1:0] led_base = 32'h0001_0000;
    localparam logic [addr_w-1:0] uart_base = 32'h0002_0000;
    localparam logic [addr_w-1:0] timer_base = 32'h0003_0000;

endpackage

// ==== verilog/soc_periph_pkg.sv ====
package soc_periph_pkg;

    // pll_clk cycles per serial bit.
    localparam int clks_per_bit = 8;

    // register offsets inside the UART region.
    localparam logic [3:0] uart_data_off = 4'h0;
    localparam logic [3:0] uart_status_off = 4'h4;

    // the 64-bit cycle counter is read as two 32-bit halves.
    localparam logic [3:0] timer_lo_off = 4'h0;
    localparam logic [3:0] timer_hi_off = 4'h4;

    localparam int led_w = 8;

endpackage

// ==== verilog/soc_top.sv ====
`timescale 1ns/100ps

module soc_top (
    input logic pll_clk,
    input logic rst_n,

    // instruction master, read only.
    input logic [soc_bus_pkg::addr_w-1:0] instr_address,
    input logic instr_read,
    output logic [soc_bus_pkg::data_w-1:0] instr_read_value,
    output logic instr_ready,

    // data master.
    input logic [soc_bus_pkg::addr_w-1:0] data_address,
    input logic data_read,
    input logic data_write,
    input logic [soc_bus_pkg::mask_w-1:0] data_write_mask,
    input logic [soc_bus_pkg::data_w-1:0] data_write_value,
    output logic [soc_bus_pkg::data_w-1:0] data_read_value,
    output logic data_ready,

    output logic [soc_periph_pkg::led_w-1:0] leds,
    output logic uart_tx
);
    import soc_bus_pkg::*;

    logic [addr_w-1:0] mem_address;
    logic mem_read;
    logic mem_write;
    logic [mask_w-1:0] mem_write_mask;
    logic [data_w-1:0] mem_write_value;

    logic ram_sel;
    logic uart_sel;
    logic periph_sel;

    logic [data_w-1:0] ram_read_value;
    logic [data_w-1:0] uart_read_value;
    logic [data_w-1:0] periph_read_value;

    bus_fabric bus_fabric (
        .pll_clk(pll_clk),
        .rst_n(rst_n),
        .instr_address(instr_address),
        .instr_read(instr_read),
        .instr_read_value(instr_read_value),
        .instr_ready(instr_ready),
        .data_address(data_address),
        .data_read(data_read),
        .data_write(data_write),
        .data_write_mask(data_write_mask),
        .data_write_value(data_write_value),
        .data_read_value(data_read_value),
        .data_ready(data_ready),
        .mem_address(mem_address),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_write_mask(mem_write_mask),
        .mem_write_value(mem_write_value),
        .ram_sel(ram_sel),
        .uart_sel(uart_sel),
        .periph_sel(periph_sel),
        .ram_read_value(ram_read_value),
        .uart_read_value(uart_read_value),
        .periph_read_value(periph_read_value)
    );

    ram ram (
        .pll_clk(pll_clk),
        .mem_address(mem_address),
        .ram_sel(ram_sel),
        .mem_write(mem_write),
        .mem_write_mask(mem_write_mask),
        .mem_write_value(mem_write_value),
        .ram_read_value(ram_read_value)
    );

    uart_tx uart (
        .pll_clk(pll_clk),
        .rst_n(rst_n),
        .mem_address(mem_address),
        .uart_sel(uart_sel),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_write_value(mem_write_value),
        .uart_read_value(uart_read_value),
        .uart_tx(uart_tx)
    );

    periph_regs periph (
        .pll_clk(pll_clk),
        .rst_n(rst_n),
        .mem_address(mem_address),
        .periph_sel(periph_sel),
        .mem_write(mem_write),
        .mem_write_mask(mem_write_mask),
        .mem_write_value(mem_write_value),
        .periph_read_value(periph_read_value),
        .leds(leds)
    );

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
    input logic pll_clk,
    input logic rst_n,

    input logic [soc_bus_pkg::addr_w-1:0] mem_address,
    input logic uart_sel,
    input logic mem_read,
    input logic mem_write,
    input logic [soc_bus_pkg::data_w-1:0] mem_write_value,
    output logic [soc_bus_pkg::data_w-1:0] uart_read_value,

    output logic uart_tx
);
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    logic busy;
    logic start;
    logic [3:0] reg_off;

    // data bits LSB first, with the stop bit above them.
    logic [8:0] shift;
    logic [$clog2(clks_per_bit)-1:0] period_cnt;
    logic [3:0] bit_cnt;
    logic period_done;

    assign reg_off = mem_address[region_bits-1:0];

    // a write while a frame is in flight is dropped.
    assign start = uart_sel && mem_write && (reg_off == uart_data_off) && !busy;

    assign period_done = (int'(period_cnt) == clks_per_bit - 1);

    always_ff @(posedge pll_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            uart_tx <= 1'b1;
            period_cnt <= '0;
            bit_cnt <= '0;
        end else if (start) begin
            busy <= 1'b1;
            uart_tx <= 1'b0;
            period_cnt <= '0;
            bit_cnt <= '0;
        end else if (busy) begin
            if (period_done) begin
                period_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    // the stop bit has just ended.
                    busy <= 1'b0;
                    uart_tx <= 1'b1;
                end else begin
                    uart_tx <= shift[0];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge pll_clk) begin
        if (start) begin
            shift <= {1'b1, mem_write_value[7:0]};
        end else if (busy && period_done) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

    // only the status register reads back, with busy in bit 0.
    always_ff @(posedge pll_clk) begin
        if (uart_sel && mem_read && (reg_off == uart_status_off)) begin
            uart_read_value <= {{(data_w-1){1'b0}}, busy};
        end else begin
            uart_read_value <= '0;
        end
    end

endmodule
